// ==== rtl/conv_1x1_pkg.sv ====
package conv_1x1_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Layer geometry
	////////////////////////////////////////////////////////////////////////////

	// Fixed-point sample width, signed
	localparam int DATA_WIDTH = 16;

	// Channel counts of the 1x1 layer
	localparam int IN_CH  = 2;
	// Must match IN_CH so the pixel FIFO drains as fast as it fills
	localparam int OUT_CH = 2;

	// One weight per output and input channel pair
	localparam int WEIGHT_NUM = IN_CH * OUT_CH;

	// Full product width plus headroom for the channel sum
	localparam int ACC_WIDTH = 2 * DATA_WIDTH + $clog2(IN_CH) + 1;

	// Pixel FIFO entries
	localparam int PIXEL_DEPTH = 4;

	////////////////////////////////////////////////////////////////////////////
	// Payload types
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [DATA_WIDTH-1:0] sample_t;
	// Element i holds input channel i
	typedef sample_t [IN_CH-1:0] pixel_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic [$clog2(OUT_CH)-1:0] och_t;

endpackage

// ==== rtl/cnn_fifo_delay.sv ====
module cnn_fifo_delay #(
	parameter type payload_t = logic [15:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     write,
	input  logic     read,
	input  payload_t data_in,
	output payload_t data_out,
	output logic     full,
	output logic     empty
);

	// Storage, no reset needed
	payload_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	logic do_read;
	logic do_write;

	// Read only with data present
	assign do_read  = read && (count != '0);
	// Write on full only when a read frees a slot in the same cycle
	assign do_write = write && ((count != DEPTH) || do_read);

	assign full  = (count == DEPTH);
	assign empty = (count == '0);

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				// Wrap at DEPTH, need not be a power of two
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Data array and registered read port
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
		// Output holds its last value between reads
		if (do_read) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

// ==== rtl/conv_1x1_buffer_weights.sv ====
module conv_1x1_buffer_weights import conv_1x1_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    valid_in,
	input  sample_t in,
	input  logic    load_weights,
	output sample_t out_buffer_weight,
	output logic    valid_out
);

	// Input stage, one cycle ahead of the FIFO write
	logic    in_valid_q;
	sample_t in_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= valid_in;
		end
	end

	// Weight value only matters with its strobe
	always_ff @(posedge clk) begin
		in_q <= in;
	end

	// Parks one full weight set until the load
	cnn_fifo_delay #(
		.payload_t(sample_t),
		.DEPTH    (WEIGHT_NUM)
	) weight_fifo_i (
		.clk     (clk),
		.reset   (reset),
		.write   (in_valid_q),
		.read    (load_weights),
		.data_in (in_q),
		.data_out(out_buffer_weight),
		.full    (),
		.empty   ()
	);

	// Sticky loaded flag, cleared only by reset
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (load_weights) begin
			valid_out <= 1'b1;
		end
	end

endmodule

// ==== rtl/pixel_packer.sv ====
module pixel_packer import conv_1x1_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    sample_valid,
	input  sample_t sample_in,
	output logic    pixel_valid,
	output pixel_t  pixel
);

	// Slot for the next incoming sample
	logic [$clog2(IN_CH)-1:0] ch;

	logic last_slot;

	// Final channel of the current pixel
	assign last_slot = (ch == IN_CH - 1);

	////////////////////////////////////////////////////////////////////////////
	// Channel counter and done pulse
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ch          <= '0;
			pixel_valid <= 1'b0;
		end else begin
			// Single-cycle pulse after the last slot fills
			pixel_valid <= sample_valid && last_slot;
			if (sample_valid) begin
				ch <= last_slot ? '0 : ch + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Slot registers
	////////////////////////////////////////////////////////////////////////////

	// Channel 0 arrives first in every pixel
	// Pixel stays intact during the pulse cycle since only slot 0 can change
	always_ff @(posedge clk) begin
		if (sample_valid) begin
			pixel[ch] <= sample_in;
		end
	end

endmodule

// ==== rtl/conv_1x1_mac.sv ====
module conv_1x1_mac import conv_1x1_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    load_weights,
	input  sample_t weight,
	input  logic    pixel_empty,
	input  pixel_t  pixel,
	output logic    pixel_pop,
	output logic    result_valid,
	output acc_t    result_data,
	output och_t    result_channel
);

	////////////////////////////////////////////////////////////////////////////
	// Weight registers
	////////////////////////////////////////////////////////////////////////////

	// Buffer FIFO output lags its read by one cycle
	logic    load_q;
	sample_t weight_q [WEIGHT_NUM];

	always_ff @(posedge clk) begin
		if (reset) begin
			load_q <= 1'b0;
		end else begin
			load_q <= load_weights;
		end
	end

	// Shift in at the top so the first weight ends at index 0
	// Index is output channel times IN_CH plus input channel
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < WEIGHT_NUM; k++) begin
				weight_q[k] <= '0;
			end
		end else if (load_q) begin
			for (int k = 0; k < WEIGHT_NUM - 1; k++) begin
				weight_q[k] <= weight_q[k+1];
			end
			weight_q[WEIGHT_NUM-1] <= weight;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	// busy means a pixel is in compute this cycle on channel och
	logic busy;
	och_t och;
	logic last_ch;
	acc_t dot;

	assign last_ch = busy && (och == OUT_CH - 1);

	// Fetch the next pixel while the last channel of this one computes
	// FIFO read port keeps the current pixel until that pop
	assign pixel_pop = !pixel_empty && (!busy || last_ch);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			och  <= '0;
		end else if (pixel_pop) begin
			// Popped pixel shows up next cycle at channel 0
			busy <= 1'b1;
			och  <= '0;
		end else if (last_ch) begin
			busy <= 1'b0;
			och  <= '0;
		end else if (busy) begin
			och <= och + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Dot product and result register
	////////////////////////////////////////////////////////////////////////////

	// Operands sign-extended to the full result width before multiply
	always_comb begin
		acc_t sum;
		sum = '0;
		for (int i = 0; i < IN_CH; i++) begin
			sum = sum + acc_t'(weight_q[och * IN_CH + i]) * acc_t'(pixel[i]);
		end
		dot = sum;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= busy;
		end
	end

	// Payload registers qualified by result_valid
	always_ff @(posedge clk) begin
		result_data    <= dot;
		result_channel <= och;
	end

endmodule

// ==== rtl/conv_1x1_top.sv ====
module conv_1x1_top import conv_1x1_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    weight_valid,
	input  sample_t weight_in,
	input  logic    load_weights,
	input  logic    sample_valid,
	input  sample_t sample_in,
	output logic    weights_loaded,
	output logic    result_valid,
	output acc_t    result_data,
	output och_t    result_channel
);

	// Weight path
	sample_t buf_weight;

	// Pixel path
	logic   pack_valid;
	pixel_t pack_pixel;
	logic   fifo_pop;
	logic   fifo_empty;
	pixel_t fifo_pixel;

	////////////////////////////////////////////////////////////////////////////
	// Weight buffer
	////////////////////////////////////////////////////////////////////////////

	conv_1x1_buffer_weights buffer_weights_i (
		.clk              (clk),
		.reset            (reset),
		.valid_in         (weight_valid),
		.in               (weight_in),
		.load_weights     (load_weights),
		.out_buffer_weight(buf_weight),
		.valid_out        (weights_loaded)
	);

	////////////////////////////////////////////////////////////////////////////
	// Pixel producer and FIFO
	////////////////////////////////////////////////////////////////////////////

	pixel_packer pixel_packer_i (
		.clk         (clk),
		.reset       (reset),
		.sample_valid(sample_valid),
		.sample_in   (sample_in),
		.pixel_valid (pack_valid),
		.pixel       (pack_pixel)
	);

	// No back-pressure to the packer, a full FIFO drops the write
	cnn_fifo_delay #(
		.payload_t(pixel_t),
		.DEPTH    (PIXEL_DEPTH)
	) pixel_fifo_i (
		.clk     (clk),
		.reset   (reset),
		.write   (pack_valid),
		.read    (fifo_pop),
		.data_in (pack_pixel),
		.data_out(fifo_pixel),
		.full    (),
		.empty   (fifo_empty)
	);

	////////////////////////////////////////////////////////////////////////////
	// Consumer
	////////////////////////////////////////////////////////////////////////////

	conv_1x1_mac mac_i (
		.clk           (clk),
		.reset         (reset),
		.load_weights  (load_weights),
		.weight        (buf_weight),
		.pixel_empty   (fifo_empty),
		.pixel         (fifo_pixel),
		.pixel_pop     (fifo_pop),
		.result_valid  (result_valid),
		.result_data   (result_data),
		.result_channel(result_channel)
	);

endmodule

// ==== dv/conv_1x1_tb.sv ====
module conv_1x1_tb import conv_1x1_pkg::*; ();

	////////////////////////////////////////////////////////////////////////////
	// Run length and timing
	////////////////////////////////////////////////////////////////////////////

	localparam int CLK_PERIOD      = 8;
	localparam int DRIVE_DELAY     = 1;
	localparam int RAND_SAMPLES    = 40;
	localparam int BURST_SAMPLES   = 64;
	localparam int RAND2_SAMPLES   = 24;
	localparam int EXTREME_SAMPLES = 8;
	localparam int TOTAL_SAMPLES   = RAND_SAMPLES + BURST_SAMPLES + RAND2_SAMPLES + EXTREME_SAMPLES;
	localparam int TIMEOUT_CYCLES  = TOTAL_SAMPLES * 4 + 200;
	localparam int MAX_GAP         = 2;
	localparam int DRAIN_CYCLES    = 32;

	localparam sample_t S_MIN = 16'h8000;
	localparam sample_t S_MAX = 16'h7fff;

	logic    clk;
	logic    reset;
	logic    weight_valid;
	sample_t weight_in;
	logic    load_weights;
	logic    sample_valid;
	sample_t sample_in;
	logic    weights_loaded;
	logic    result_valid;
	acc_t    result_data;
	och_t    result_channel;

	conv_1x1_top conv_1x1_top_i (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.weight_in     (weight_in),
		.load_weights  (load_weights),
		.sample_valid  (sample_valid),
		.sample_in     (sample_in),
		.weights_loaded(weights_loaded),
		.result_valid  (result_valid),
		.result_data   (result_data),
		.result_channel(result_channel)
	);

	// Free-running clock
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////////////////////////////////////////

	integer  seed = 32'hdd3f_dada;
	int      value_errors;
	int      seq_errors;
	int      result_count;
	int      burst_start;
	// Weights of the active set, in write order
	sample_t model_w [WEIGHT_NUM];
	sample_t set_w [WEIGHT_NUM];
	sample_t model_pix [IN_CH];
	int      model_ch;
	// Expected results, oldest first
	longint  exp_data [$];
	int      exp_ch [$];
	logic    load_started;
	logic    expect_loaded;
	longint  mon_data;
	int      mon_ch;

	function automatic sample_t random_sample();
		int r;
		r = $random(seed);
		return r[DATA_WIDTH-1:0];
	endfunction

	function automatic int random_gap();
		int r;
		r = $random(seed);
		return $unsigned(r) % (MAX_GAP + 1);
	endfunction

	// Signed dot product, weight k maps to och k div IN_CH and ich k mod IN_CH
	function automatic longint expected_dot(int o);
		longint sum;
		sum = 0;
		for (int i = 0; i < IN_CH; i++) begin
			sum = sum + longint'(model_w[o * IN_CH + i]) * longint'(model_pix[i]);
		end
		return sum;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// Step to just after the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic load_weight_set(input sample_t w [WEIGHT_NUM]);
		for (int k = 0; k < WEIGHT_NUM; k++) begin
			next_cycle();
			weight_valid = 1'b1;
			weight_in    = w[k];
		end
		next_cycle();
		weight_valid = 1'b0;
		weight_in    = '0;
		// Last weight needs two cycles to land in the FIFO
		repeat (2) next_cycle();
		load_started = 1'b1;
		repeat (WEIGHT_NUM) begin
			next_cycle();
			load_weights = 1'b1;
		end
		next_cycle();
		load_weights = 1'b0;
		repeat (2) next_cycle();
		model_w       = w;
		expect_loaded = 1'b1;
	endtask

	// Leaves sample_valid high when gap is zero, for back-to-back streams
	task automatic send_sample(input sample_t s, input int gap);
		next_cycle();
		sample_valid = 1'b1;
		sample_in    = s;
		model_pix[model_ch] = s;
		if (model_ch == IN_CH - 1) begin
			model_ch = 0;
			for (int o = 0; o < OUT_CH; o++) begin
				exp_data.push_back(expected_dot(o));
				exp_ch.push_back(o);
			end
		end else begin
			model_ch++;
		end
		repeat (gap) begin
			next_cycle();
			sample_valid = 1'b0;
		end
	endtask

	task automatic end_stream();
		next_cycle();
		sample_valid = 1'b0;
		sample_in    = '0;
	endtask

	// Bounded wait for pending results
	task automatic drain_results();
		int waited;
		waited = 0;
		while (exp_data.size() != 0 && waited < DRAIN_CYCLES) begin
			next_cycle();
			waited++;
		end
		// Quiet cycles so stray results show up
		repeat (4) next_cycle();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////////////////////

	// Falling edge, registered outputs settled
	always @(negedge clk) begin
		if (!reset) begin
			if (!load_started) begin
				assert (!weights_loaded) else begin
					$display("** Error at %0t: weights_loaded high before any load", $time);
					value_errors++;
				end
			end
			// Sticky once a load has finished
			if (expect_loaded) begin
				assert (weights_loaded) else begin
					$display("** Error at %0t: weights_loaded dropped after load", $time);
					value_errors++;
				end
			end
			if (result_valid) begin
				result_count++;
				assert (exp_data.size() != 0) else begin
					$display("Result on channel %0d arrived with no pixel pending",
						result_channel);
					seq_errors++;
				end
				if (exp_data.size() != 0) begin
					mon_data = exp_data.pop_front();
					mon_ch   = exp_ch.pop_front();
					assert (int'(result_channel) == mon_ch) else begin
						$display("** Error at %0t: result_channel %0d, expected %0d",
							$time, result_channel, mon_ch);
						value_errors++;
					end
					assert (longint'(result_data) == mon_data) else begin
						$display("** Error at %0t: channel %0d result %0d, expected %0d",
							$time, mon_ch, result_data, mon_data);
						value_errors++;
					end
				end
			end
		end
	end

	// Watchdog sized from the sample count
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		reset         = 1'b1;
		weight_valid  = 1'b0;
		weight_in     = '0;
		load_weights  = 1'b0;
		sample_valid  = 1'b0;
		sample_in     = '0;
		value_errors  = 0;
		seq_errors    = 0;
		result_count  = 0;
		model_ch      = 0;
		load_started  = 1'b0;
		expect_loaded = 1'b0;
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// Idle after reset, both flags low
		@(negedge clk);
		assert (!weights_loaded && !result_valid) else begin
			$display("** Error at %0t: outputs not low after reset", $time);
			value_errors++;
		end
		repeat (8) next_cycle();

		// First random weight set
		for (int k = 0; k < WEIGHT_NUM; k++) begin
			set_w[k] = random_sample();
		end
		load_weight_set(set_w);

		// Random pixels with idle gaps
		for (int n = 0; n < RAND_SAMPLES; n++) begin
			send_sample(random_sample(), random_gap());
		end
		end_stream();
		drain_results();

		// Full-rate burst through the pixel FIFO
		burst_start = result_count;
		for (int n = 0; n < BURST_SAMPLES; n++) begin
			send_sample(random_sample(), 0);
		end
		end_stream();
		drain_results();
		assert (result_count - burst_start == BURST_SAMPLES / IN_CH * OUT_CH) else begin
			$display("Burst gave %0d results instead of %0d",
				result_count - burst_start, BURST_SAMPLES / IN_CH * OUT_CH);
			seq_errors++;
		end

		// Second set while idle
		for (int k = 0; k < WEIGHT_NUM; k++) begin
			set_w[k] = random_sample();
		end
		load_weight_set(set_w);
		for (int n = 0; n < RAND2_SAMPLES; n++) begin
			send_sample(random_sample(), random_gap());
		end
		end_stream();
		drain_results();

		// Extremes, MIN times MIN summed overflows 32 bits
		set_w[0] = S_MIN;
		set_w[1] = S_MIN;
		set_w[2] = S_MAX;
		set_w[3] = S_MIN;
		load_weight_set(set_w);
		send_sample(S_MIN, 0);
		send_sample(S_MIN, 0);
		send_sample(S_MAX, 0);
		send_sample(S_MAX, 0);
		send_sample(S_MIN, 0);
		send_sample(S_MAX, 0);
		send_sample(S_MAX, 0);
		send_sample(S_MIN, 0);
		end_stream();
		drain_results();

		assert (exp_data.size() == 0) else begin
			$display("%0d expected results never arrived", exp_data.size());
			seq_errors++;
		end

		$display("Checks done: %0d value errors, %0d sequence errors",
			value_errors, seq_errors);
		if (value_errors == 0 && seq_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== conv_1x1_top.f ====
rtl/conv_1x1_pkg.sv
rtl/cnn_fifo_delay.sv
rtl/conv_1x1_buffer_weights.sv
rtl/pixel_packer.sv
rtl/conv_1x1_mac.sv
rtl/conv_1x1_top.sv
dv/conv_1x1_tb.sv

// ==== Makefile ====
TOP = conv_1x1_tb
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f conv_1x1_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
